/* logic/mem_ctrl_params.svh */
// ------------------------------------------------
// memory controller geometry
// bank count, line size and address widths shared
// by the package and the RTL blocks
// ------------------------------------------------
`ifndef MEM_CTRL_PARAMS_SVH
`define MEM_CTRL_PARAMS_SVH

// sixteen banks, eight regions of two banks each
`define MC_NUM_BANKS 16

// one bank line is 32 bytes wide
`define MC_LINE_BYTES 32

// client byte address, region in the top three bits
`define MC_ADDR_W 19

// rows per bank, taken from address bits 15..6
`define MC_ROW_W 10

`endif

/* logic/mem_ctrl_pkg.sv */
// ------------------------------------------------
// memory controller package
// shared payload types and the address mapping of
// a client byte address onto bank, row and offset
// ------------------------------------------------
`include "mem_ctrl_params.svh"

package mem_ctrl_pkg;

	typedef logic [`MC_ADDR_W-1:0]         addr_t;
	// access size in bytes, 1 to 32
	typedef logic [5:0]                    size_t;
	typedef logic [3:0]                    bank_t;
	typedef logic [`MC_ROW_W-1:0]          row_t;
	typedef logic [`MC_LINE_BYTES*8-1:0]   line_t;
	typedef logic [`MC_LINE_BYTES-1:0]     be_t;

	// the region (bits 18..16) followed by the bank parity bit (bit 5)
	function automatic bank_t bank_of(input addr_t a);
		return {a[18:16], a[5]};
	endfunction

	// row inside the bank sits between the parity bit and the region
	function automatic row_t row_of(input addr_t a);
		return a[15:6];
	endfunction

	// true when the access runs past the end of its line
	function automatic logic crosses_line(input addr_t a, input size_t s);
		logic [6:0] end_byte;
		end_byte = {2'b00, a[4:0]} + {1'b0, s};
		return end_byte > 7'(`MC_LINE_BYTES);
	endfunction

endpackage

/* logic/line_req_if.sv */
// ------------------------------------------------
// line request interface
// carries one line request from a read or write
// path to the bank-port combiner
// ------------------------------------------------
`timescale 1ns/1ps

interface line_req_if;
	import mem_ctrl_pkg::*;

	// level, held with stable fields until gnt
	logic  req;
	bank_t bank;
	row_t  row;
	line_t wdata;
	be_t   be;
	// one-cycle pulse, req drops in the cycle after it
	logic  gnt;
	// valid in the cycle after gnt for a read line
	line_t rdata;

	// the requesting side, a read or write path
	modport path (
		output req, bank, row, wdata, be,
		input  gnt, rdata
	);

	// the combiner side that owns the bank ports
	modport mux (
		input  req, bank, row, wdata, be,
		output gnt, rdata
	);

endinterface

/* logic/read_path.sv */
// ------------------------------------------------
// read path
// splits a client read into one or two line
// requests, collects both lines and returns the
// requested bytes realigned to byte 0
// ------------------------------------------------
`timescale 1ns/1ps
`include "mem_ctrl_params.svh"

module read_path (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 rd_req,
	input  mem_ctrl_pkg::addr_t  rd_addr,
	input  mem_ctrl_pkg::size_t  rd_size,
	output logic                 rd_valid,
	output mem_ctrl_pkg::line_t  rd_data,
	line_req_if.path             first,
	line_req_if.path             second
);
	import mem_ctrl_pkg::*;

	typedef enum logic [1:0] {IDLE, REQ, RESP} state_t;

	state_t state;
	addr_t  addr_q;
	addr_t  second_addr;
	size_t  size_q;
	logic   pend_first, pend_second;
	logic   gnt_d_first, gnt_d_second;
	logic   lines_done;
	line_t  buf_first, buf_second;
	logic [2*`MC_LINE_BYTES*8-1:0] pair;
	line_t  aligned;

	// ------------------------------------------------
	// line requests
	// ------------------------------------------------
	// the second line is simply the next 32 bytes, wrapping past the top
	assign second_addr = addr_q + addr_t'(`MC_LINE_BYTES);

	assign first.req    = pend_first;
	assign first.bank   = bank_of(addr_q);
	assign first.row    = row_of(addr_q);
	assign first.wdata  = '0;
	assign first.be     = '0;

	assign second.req   = pend_second;
	assign second.bank  = bank_of(second_addr);
	assign second.row   = row_of(second_addr);
	assign second.wdata = '0;
	assign second.be    = '0;

	// all issued lines granted and their data already in the buffer
	assign lines_done = !pend_first && !pend_second && !gnt_d_first && !gnt_d_second;

	// ------------------------------------------------
	// control FSM
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= IDLE;
			pend_first   <= 1'b0;
			pend_second  <= 1'b0;
			gnt_d_first  <= 1'b0;
			gnt_d_second <= 1'b0;
			rd_valid     <= 1'b0;
		end else begin
			// rdata follows gnt by one cycle, so remember which line was granted
			gnt_d_first  <= first.gnt;
			gnt_d_second <= second.gnt;
			rd_valid     <= 1'b0;
			case (state)
				IDLE: begin
					if (rd_req) begin
						state       <= REQ;
						pend_first  <= 1'b1;
						pend_second <= crosses_line(rd_addr, rd_size);
					end
				end
				REQ: begin
					if (first.gnt)
						pend_first <= 1'b0;
					if (second.gnt)
						pend_second <= 1'b0;
					if (lines_done) begin
						rd_valid <= 1'b1;
						state    <= RESP;
					end
				end
				// pulse cycle, the client still holds its old request here
				RESP: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// request fields and line data, loaded on acceptance and on each capture
	always_ff @(posedge clk) begin
		if (state == IDLE && rd_req) begin
			addr_q <= rd_addr;
			size_q <= rd_size;
		end
		if (gnt_d_first)
			buf_first <= first.rdata;
		if (gnt_d_second)
			buf_second <= second.rdata;
	end

	// ------------------------------------------------
	// realignment
	// ------------------------------------------------
	// the two lines form one 64-byte window, shifted down by the offset;
	// bytes past the size are cleared, which also hides a stale second line
	always_comb begin
		pair    = {buf_second, buf_first} >> {addr_q[4:0], 3'b000};
		aligned = pair[`MC_LINE_BYTES*8-1:0];
		for (int k = 0; k < `MC_LINE_BYTES; k++) begin
			if (k >= int'(size_q))
				aligned[k*8 +: 8] = 8'h00;
		end
	end

	always_ff @(posedge clk) begin
		if (state == REQ && lines_done)
			rd_data <= aligned;
	end

	// no response while a line request is still waiting at the combiner
	a_valid_after_grants: assert property (
		@(posedge clk) disable iff (!rst_n)
		rd_valid |-> !(first.req || second.req)
	);

endmodule

/* logic/write_path.sv */
// ------------------------------------------------
// write path
// places client write data into line position,
// builds the byte enables of one or two lines and
// acknowledges after the last grant
// ------------------------------------------------
`timescale 1ns/1ps
`include "mem_ctrl_params.svh"

module write_path (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 wr_req,
	input  mem_ctrl_pkg::addr_t  wr_addr,
	input  mem_ctrl_pkg::size_t  wr_size,
	input  mem_ctrl_pkg::line_t  wr_data,
	output logic                 wr_ack,
	line_req_if.path             first,
	line_req_if.path             second
);
	import mem_ctrl_pkg::*;

	typedef enum logic [1:0] {IDLE, REQ, ACK} state_t;

	state_t state;
	addr_t  addr_q;
	addr_t  second_addr;
	size_t  size_q;
	line_t  data_q;
	logic   pend_first, pend_second;
	size_t  room, n_first, n_second;
	be_t    be_first, be_second;

	// ------------------------------------------------
	// byte split between the two lines
	// ------------------------------------------------
	always_comb begin
		room     = size_t'(`MC_LINE_BYTES) - {1'b0, addr_q[4:0]};
		n_first  = (size_q > room) ? room : size_q;
		// zero when the write fits in one line
		n_second = size_q - n_first;
		for (int k = 0; k < `MC_LINE_BYTES; k++) begin
			be_first[k]  = (k >= int'(addr_q[4:0])) && (k < int'(addr_q[4:0]) + int'(n_first));
			be_second[k] = k < int'(n_second);
		end
	end

	assign second_addr = addr_q + addr_t'(`MC_LINE_BYTES);

	assign first.req    = pend_first;
	assign first.bank   = bank_of(addr_q);
	assign first.row    = row_of(addr_q);
	assign first.wdata  = data_q << {addr_q[4:0], 3'b000};
	assign first.be     = be_first;

	// the bytes that did not fit start at byte 0 of the next line
	assign second.req   = pend_second;
	assign second.bank  = bank_of(second_addr);
	assign second.row   = row_of(second_addr);
	assign second.wdata = data_q >> {n_first, 3'b000};
	assign second.be    = be_second;

	// ------------------------------------------------
	// control FSM
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= IDLE;
			pend_first  <= 1'b0;
			pend_second <= 1'b0;
			wr_ack      <= 1'b0;
		end else begin
			wr_ack <= 1'b0;
			case (state)
				IDLE: begin
					if (wr_req) begin
						state       <= REQ;
						pend_first  <= 1'b1;
						pend_second <= crosses_line(wr_addr, wr_size);
					end
				end
				REQ: begin
					if (first.gnt)
						pend_first <= 1'b0;
					if (second.gnt)
						pend_second <= 1'b0;
					// ack once nothing is left pending after this cycle's grants
					if (!(pend_first && !first.gnt) && !(pend_second && !second.gnt)) begin
						wr_ack <= 1'b1;
						state  <= ACK;
					end
				end
				ACK: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && wr_req) begin
			addr_q <= wr_addr;
			size_q <= wr_size;
			data_q <= wr_data;
		end
	end

	// the two lines together write exactly the bytes the client asked for
	a_be_count: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state == REQ) |-> ($countones(be_first) + $countones(be_second) == int'(wr_size))
	);

endmodule

/* logic/bank_port_mux.sv */
// ------------------------------------------------
// bank-port combiner
// merges the read and write line requests onto
// the bank ports, read lines first, and returns
// grants and read data to the owners
// ------------------------------------------------
`timescale 1ns/1ps
`include "mem_ctrl_params.svh"

module bank_port_mux (
	line_req_if.mux                                     rd_first,
	line_req_if.mux                                     rd_second,
	line_req_if.mux                                     wr_first,
	line_req_if.mux                                     wr_second,
	output logic [`MC_NUM_BANKS-1:0]                    bank_req,
	output logic [`MC_NUM_BANKS-1:0]                    bank_we,
	output mem_ctrl_pkg::row_t  [`MC_NUM_BANKS-1:0]     bank_row,
	output mem_ctrl_pkg::line_t [`MC_NUM_BANKS-1:0]     bank_wdata,
	output mem_ctrl_pkg::be_t   [`MC_NUM_BANKS-1:0]     bank_be,
	input  logic [`MC_NUM_BANKS-1:0]                    bank_gnt,
	input  mem_ctrl_pkg::line_t [`MC_NUM_BANKS-1:0]     bank_rdata
);
	import mem_ctrl_pkg::*;

	// sources in priority order, the two read lines come first
	localparam int NUM_SRC = 4;
	localparam logic [NUM_SRC-1:0] SRC_IS_WR = 4'b1100;

	logic [NUM_SRC-1:0] src_req;
	logic [NUM_SRC-1:0] src_gnt;
	bank_t              src_bank  [NUM_SRC];
	row_t               src_row   [NUM_SRC];
	line_t              src_wdata [NUM_SRC];
	be_t                src_be    [NUM_SRC];
	logic [`MC_NUM_BANKS-1:0] owned;
	logic [1:0]         owner [`MC_NUM_BANKS];

	assign src_req   = {wr_second.req, wr_first.req, rd_second.req, rd_first.req};
	assign src_bank  = '{rd_first.bank, rd_second.bank, wr_first.bank, wr_second.bank};
	assign src_row   = '{rd_first.row, rd_second.row, wr_first.row, wr_second.row};
	assign src_wdata = '{rd_first.wdata, rd_second.wdata, wr_first.wdata, wr_second.wdata};
	assign src_be    = '{rd_first.be, rd_second.be, wr_first.be, wr_second.be};

	// ------------------------------------------------
	// per-bank owner selection
	// ------------------------------------------------
	always_comb begin
		for (int b = 0; b < `MC_NUM_BANKS; b++) begin
			owned[b] = 1'b0;
			owner[b] = 2'd0;
			// the first requesting source on this bank wins
			for (int s = 0; s < NUM_SRC; s++) begin
				if (!owned[b] && src_req[s] && src_bank[s] == bank_t'(b)) begin
					owned[b] = 1'b1;
					owner[b] = 2'(s);
				end
			end
			bank_req[b]   = owned[b];
			bank_we[b]    = owned[b] && SRC_IS_WR[owner[b]];
			bank_row[b]   = owned[b] ? src_row[owner[b]] : '0;
			bank_wdata[b] = owned[b] ? src_wdata[owner[b]] : '0;
			bank_be[b]    = owned[b] ? src_be[owner[b]] : '0;
		end
	end

	// a bank grant reaches only the source that owns the bank this cycle
	always_comb begin
		for (int s = 0; s < NUM_SRC; s++) begin
			src_gnt[s] = src_req[s] && bank_gnt[src_bank[s]] &&
				owned[src_bank[s]] && owner[src_bank[s]] == 2'(s);
		end
	end

	assign rd_first.gnt  = src_gnt[0];
	assign rd_second.gnt = src_gnt[1];
	assign wr_first.gnt  = src_gnt[2];
	assign wr_second.gnt = src_gnt[3];

	// the read path keeps its bank fields steady through the data cycle
	assign rd_first.rdata  = bank_rdata[rd_first.bank];
	assign rd_second.rdata = bank_rdata[rd_second.bank];
	assign wr_first.rdata  = '0;
	assign wr_second.rdata = '0;

	// a bank only grants while it has a request on its port
	always_comb begin
		a_gnt_with_req: assert #0 ((bank_gnt & ~bank_req) == '0)
			else $error("bank_gnt without bank_req: gnt=%h req=%h", bank_gnt, bank_req);
	end

endmodule

/* logic/mem_req_ctrl.sv */
// ------------------------------------------------
// client-to-SRAM request controller, top level
// one client with independent read and write
// paths sharing sixteen banks through a combiner
// ------------------------------------------------
`timescale 1ns/1ps
`include "mem_ctrl_params.svh"

module mem_req_ctrl (
	input  logic                                        clk,
	input  logic                                        rst_n,
	// client read side
	input  logic                                        rd_req,
	input  mem_ctrl_pkg::addr_t                         rd_addr,
	input  mem_ctrl_pkg::size_t                         rd_size,
	output logic                                        rd_valid,
	output mem_ctrl_pkg::line_t                         rd_data,
	// client write side
	input  logic                                        wr_req,
	input  mem_ctrl_pkg::addr_t                         wr_addr,
	input  mem_ctrl_pkg::size_t                         wr_size,
	input  mem_ctrl_pkg::line_t                         wr_data,
	output logic                                        wr_ack,
	// bank ports
	output logic [`MC_NUM_BANKS-1:0]                    bank_req,
	output logic [`MC_NUM_BANKS-1:0]                    bank_we,
	output mem_ctrl_pkg::row_t  [`MC_NUM_BANKS-1:0]     bank_row,
	output mem_ctrl_pkg::line_t [`MC_NUM_BANKS-1:0]     bank_wdata,
	output mem_ctrl_pkg::be_t   [`MC_NUM_BANKS-1:0]     bank_be,
	input  logic [`MC_NUM_BANKS-1:0]                    bank_gnt,
	input  mem_ctrl_pkg::line_t [`MC_NUM_BANKS-1:0]     bank_rdata
);

	// ------------------------------------------------
	// line request channels, two per path
	// ------------------------------------------------
	line_req_if rd_first ();
	line_req_if rd_second ();
	line_req_if wr_first ();
	line_req_if wr_second ();

	read_path u_read_path (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_req   (rd_req),
		.rd_addr  (rd_addr),
		.rd_size  (rd_size),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.first    (rd_first),
		.second   (rd_second)
	);

	write_path u_write_path (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_req   (wr_req),
		.wr_addr  (wr_addr),
		.wr_size  (wr_size),
		.wr_data  (wr_data),
		.wr_ack   (wr_ack),
		.first    (wr_first),
		.second   (wr_second)
	);

	// combinational, reads win on a shared bank
	bank_port_mux u_bank_port_mux (
		.rd_first   (rd_first),
		.rd_second  (rd_second),
		.wr_first   (wr_first),
		.wr_second  (wr_second),
		.bank_req   (bank_req),
		.bank_we    (bank_we),
		.bank_row   (bank_row),
		.bank_wdata (bank_wdata),
		.bank_be    (bank_be),
		.bank_gnt   (bank_gnt),
		.bank_rdata (bank_rdata)
	);

endmodule

/* tb/mem_req_ctrl_checker.sv */
// ------------------------------------------------
// request controller checker
// keeps a shadow byte memory, predicts every read
// and the banks it must touch, compares at each
// rd_valid and reports per test
// ------------------------------------------------
`timescale 1ns/1ps

module mem_req_ctrl_checker (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 rd_valid,
	input  mem_ctrl_pkg::line_t  rd_data,
	input  mem_ctrl_pkg::addr_t  rd_addr,
	input  mem_ctrl_pkg::size_t  rd_size,
	input  logic                 wr_ack,
	input  mem_ctrl_pkg::addr_t  wr_addr,
	input  mem_ctrl_pkg::size_t  wr_size,
	input  mem_ctrl_pkg::line_t  wr_data,
	input  logic [15:0]          bank_req,
	input  logic [15:0]          bank_we,
	input  int                   test_id,
	input  logic                 test_end,
	input  logic                 run_end,
	input  int                   other_errs,
	output int                   err_total
);
	import mem_ctrl_pkg::*;

	localparam int LINE_BYTES = 32;

	// bytes the client has written, by byte address
	logic [7:0]  shadow [int];
	int          cmp_errs   = 0;
	int          checks     = 0;
	int          tests_done = 0;
	int          err_mark   = 0;
	int          check_mark = 0;
	logic        reset_seen = 1'b0;
	// banks that carried a read line since the last rd_valid
	logic [15:0] rd_banks   = '0;

	assign err_total = cmp_errs + other_errs;

	function automatic string test_name(input int id);
		case (id)
			1: return "reset_state";
			2: return "single_line_read";
			3: return "crossing_read";
			4: return "write_readback";
			5: return "parallel_rd_wr";
			6: return "random_mixed";
			default: return "unknown";
		endcase
	endfunction

	// same fold as the bank model, an unwritten byte is a function of its address
	function automatic logic [7:0] fill_byte(input addr_t a);
		return a[7:0] ^ a[15:8] ^ {5'b00000, a[18:16]} ^ 8'h5a;
	endfunction

	function automatic logic [7:0] shadow_byte(input addr_t a);
		return shadow.exists(int'(a)) ? shadow[int'(a)] : fill_byte(a);
	endfunction

	// reference read: requested bytes from byte 0 up, addresses wrap at the top,
	// everything past the size is zero
	function automatic line_t read_model(input addr_t a, input size_t s);
		line_t r;
		r = '0;
		for (int k = 0; k < LINE_BYTES; k++) begin
			if (k < int'(s))
				r[k*8 +: 8] = shadow_byte(a + addr_t'(k));
		end
		return r;
	endfunction

	// bank is region then parity bit, a second line sits 32 bytes on
	function automatic logic [15:0] bank_set(input addr_t a, input size_t s);
		addr_t       nxt;
		logic [15:0] banks;
		nxt   = a + addr_t'(LINE_BYTES);
		banks = 16'(1) << {a[18:16], a[5]};
		if (int'(a[4:0]) + int'(s) > LINE_BYTES)
			banks = banks | (16'(1) << {nxt[18:16], nxt[5]});
		return banks;
	endfunction

	// ------------------------------------------------
	// compare process
	// ------------------------------------------------
	always @(posedge clk) begin : compare
		line_t       exp_data;
		logic [15:0] exp_banks;
		if (!rst_n) begin
			reset_seen = 1'b0;
			rd_banks   = '0;
		end else begin
			// first cycle after reset, nothing may be pending or pulsing
			if (!reset_seen) begin
				reset_seen = 1'b1;
				checks++;
				if ({rd_valid, wr_ack, bank_req} !== 18'd0) begin
					cmp_errs++;
					$display("FAIL %s: outputs after reset expected %h, actual %h",
						test_name(test_id), 18'd0, {rd_valid, wr_ack, bank_req});
				end
			end
			rd_banks = rd_banks | (bank_req & ~bank_we);
			if (rd_valid) begin
				exp_data  = read_model(rd_addr, rd_size);
				exp_banks = bank_set(rd_addr, rd_size);
				checks += 2;
				if (rd_data !== exp_data) begin
					cmp_errs++;
					$display("FAIL %s: rd_data at %h size %0d expected %h, actual %h",
						test_name(test_id), rd_addr, rd_size, exp_data, rd_data);
				end
				if (rd_banks !== exp_banks) begin
					cmp_errs++;
					$display("FAIL %s: read banks at %h size %0d expected %h, actual %h",
						test_name(test_id), rd_addr, rd_size, exp_banks, rd_banks);
				end
				rd_banks = '0;
			end
			// the write is in the banks by the time wr_ack pulses
			if (wr_ack) begin
				for (int k = 0; k < LINE_BYTES; k++) begin
					if (k < int'(wr_size))
						shadow[int'(wr_addr + addr_t'(k))] = wr_data[k*8 +: 8];
				end
			end
			if (test_end) begin
				tests_done++;
				$display("%s: %0d checks, %0d errors", test_name(test_id),
					checks - check_mark, cmp_errs + other_errs - err_mark);
				check_mark = checks;
				err_mark   = cmp_errs + other_errs;
			end
			if (run_end)
				$display("tests %0d, checks %0d, errors %0d", tests_done, checks,
					cmp_errs + other_errs);
		end
	end

endmodule

/* tb/mem_req_ctrl_tb.sv */
// ------------------------------------------------
// request controller testbench
// clock, reset, client stimulus, a byte-level bank
// model with random grant delays, and the checker
// ------------------------------------------------
`timescale 1ns/1ps

module mem_req_ctrl_tb;
	import mem_ctrl_pkg::*;

	localparam int NUM_BANKS = 16;
	localparam int LINE_BYTES = 32;
	// cycles any single wait may last before it counts as a failure
	localparam int TIMEOUT = 200;
	localparam int RANDOM_OPS = 200;
	localparam logic [31:0] SEED = 32'h41d6_4855;

	logic clk;
	logic rst_n = 1'b0;

	// client side
	logic  rd_req  = 1'b0;
	addr_t rd_addr = '0;
	size_t rd_size = '0;
	logic  rd_valid;
	line_t rd_data;
	logic  wr_req  = 1'b0;
	addr_t wr_addr = '0;
	size_t wr_size = '0;
	line_t wr_data = '0;
	logic  wr_ack;

	// bank side
	logic [NUM_BANKS-1:0]       bank_req;
	logic [NUM_BANKS-1:0]       bank_we;
	logic [NUM_BANKS-1:0][9:0]  bank_row;
	line_t [NUM_BANKS-1:0]      bank_wdata;
	logic [NUM_BANKS-1:0][31:0] bank_be;
	logic [NUM_BANKS-1:0]       bank_gnt   = '0;
	line_t [NUM_BANKS-1:0]      bank_rdata = '0;

	// test bookkeeping shared with the checker, test 1 runs straight out of reset
	int   test_id    = 1;
	logic test_end   = 1'b0;
	logic run_end    = 1'b0;
	int   other_errs = 0;
	int   err_total;

	// stimulus and grant delays each step their own LFSR
	logic [31:0] stim_lfsr = SEED;
	logic [31:0] gnt_lfsr  = SEED;

	// written bytes of the bank model, keyed by client byte address
	logic [7:0] bank_mem [int];
	int         gnt_wait [NUM_BANKS];

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	mem_req_ctrl u_mem_req_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_req     (rd_req),
		.rd_addr    (rd_addr),
		.rd_size    (rd_size),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data),
		.wr_req     (wr_req),
		.wr_addr    (wr_addr),
		.wr_size    (wr_size),
		.wr_data    (wr_data),
		.wr_ack     (wr_ack),
		.bank_req   (bank_req),
		.bank_we    (bank_we),
		.bank_row   (bank_row),
		.bank_wdata (bank_wdata),
		.bank_be    (bank_be),
		.bank_gnt   (bank_gnt),
		.bank_rdata (bank_rdata)
	);

	mem_req_ctrl_checker u_checker (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data),
		.rd_addr    (rd_addr),
		.rd_size    (rd_size),
		.wr_ack     (wr_ack),
		.wr_addr    (wr_addr),
		.wr_size    (wr_size),
		.wr_data    (wr_data),
		.bank_req   (bank_req),
		.bank_we    (bank_we),
		.test_id    (test_id),
		.test_end   (test_end),
		.run_end    (run_end),
		.other_errs (other_errs),
		.err_total  (err_total)
	);

	// ------------------------------------------------
	// random numbers
	// ------------------------------------------------
	// right-shifting Galois form, taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step per bit, the bits collect from the top down
	task automatic draw(inout logic [31:0] st, input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], st[0]};
			st  = lfsr_next(st);
		end
	endtask

	task automatic random_line(output line_t l);
		logic [31:0] w;
		for (int i = 0; i < LINE_BYTES / 4; i++) begin
			draw(stim_lfsr, 32, w);
			l[i*32 +: 32] = w;
		end
	endtask

	// ------------------------------------------------
	// bank model
	// ------------------------------------------------
	// unwritten bytes read as the whole address folded into a byte, XOR 5a
	function automatic logic [7:0] fill_byte(input addr_t a);
		return a[7:0] ^ a[15:8] ^ {5'b00000, a[18:16]} ^ 8'h5a;
	endfunction

	function automatic logic [7:0] mem_byte(input int a);
		return bank_mem.exists(a) ? bank_mem[a] : fill_byte(addr_t'(a));
	endfunction

	// a requesting bank waits 0 to 3 cycles, then grants for one cycle;
	// the access itself uses the port fields of the grant cycle
	always @(posedge clk) begin : grant_model
		logic [3:0]  bn;
		addr_t       base;
		line_t       line;
		logic [31:0] delay;
		if (!rst_n) begin
			bank_gnt <= '0;
			for (int b = 0; b < NUM_BANKS; b++)
				gnt_wait[b] <= 0;
		end else begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				bn = 4'(b);
				// region bits, row, then the parity bit rebuild the line address
				base = {bn[3:1], bank_row[b], bn[0], 5'd0};
				if (bank_gnt[b]) begin
					bank_gnt[b] <= 1'b0;
					if (bank_we[b]) begin
						for (int k = 0; k < LINE_BYTES; k++) begin
							if (bank_be[b][k])
								bank_mem[int'(base) + k] = bank_wdata[b][k*8 +: 8];
						end
					end else begin
						for (int k = 0; k < LINE_BYTES; k++)
							line[k*8 +: 8] = mem_byte(int'(base) + k);
						bank_rdata[b] <= line;
					end
				end else if (bank_req[b]) begin
					if (gnt_wait[b] == 0) begin
						bank_gnt[b] <= 1'b1;
						draw(gnt_lfsr, 2, delay);
						gnt_wait[b] <= int'(delay);
					end else begin
						gnt_wait[b] <= gnt_wait[b] - 1;
					end
				end
			end
		end
	end

	// ------------------------------------------------
	// client tasks
	// ------------------------------------------------
	// request held until rd_valid, dropped on the edge that sees the pulse
	task automatic read_bytes(input addr_t a, input size_t s);
		int waited;
		@(posedge clk);
		rd_req  <= 1'b1;
		rd_addr <= a;
		rd_size <= s;
		waited = 0;
		@(posedge clk);
		while (!rd_valid && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (!rd_valid) begin
			other_errs++;
			$display("read from %h of %0d bytes returned no rd_valid within %0d cycles",
				a, s, TIMEOUT);
		end
		rd_req <= 1'b0;
	endtask

	task automatic write_bytes(input addr_t a, input size_t s, input line_t d);
		int waited;
		@(posedge clk);
		wr_req  <= 1'b1;
		wr_addr <= a;
		wr_size <= s;
		wr_data <= d;
		waited = 0;
		@(posedge clk);
		while (!wr_ack && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (!wr_ack) begin
			other_errs++;
			$display("write to %h of %0d bytes got no wr_ack within %0d cycles",
				a, s, TIMEOUT);
		end
		wr_req <= 1'b0;
	endtask

	task automatic begin_test(input int id);
		@(posedge clk);
		test_id <= id;
	endtask

	// the checker reports the test on the edge that sees test_end
	task automatic end_test();
		@(posedge clk);
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	// ------------------------------------------------
	// test sequence
	// ------------------------------------------------
	initial begin : stimulus
		line_t       l;
		addr_t       a;
		size_t       s;
		logic [31:0] op;
		logic [31:0] rgn;
		logic [31:0] low;
		logic [31:0] sz;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		// the checker looks at the outputs on the first cycle out of reset
		repeat (2) @(posedge clk);
		end_test();

		begin_test(2);
		read_bytes(19'h00000, 6'd32);
		read_bytes(19'h12343, 6'd7);
		read_bytes(19'h7001f, 6'd1);
		read_bytes(19'h20020, 6'd32);
		read_bytes(19'h3a5c1, 6'd31);
		end_test();

		// the second one steps from region 1 into region 2, the third wraps to zero
		begin_test(3);
		read_bytes(19'h00010, 6'd32);
		read_bytes(19'h1fff5, 6'd20);
		read_bytes(19'h7fffc, 6'd8);
		read_bytes(19'h3001e, 6'd3);
		end_test();

		begin_test(4);
		random_line(l);
		write_bytes(19'h04105, 6'd5, l);
		read_bytes(19'h04100, 6'd16);
		random_line(l);
		write_bytes(19'h0423c, 6'd12, l);
		read_bytes(19'h04230, 6'd32);
		read_bytes(19'h04240, 6'd16);
		random_line(l);
		write_bytes(19'h04400, 6'd32, l);
		read_bytes(19'h043f8, 6'd32);
		random_line(l);
		write_bytes(19'h04107, 6'd1, l);
		read_bytes(19'h04100, 6'd16);
		end_test();

		// both pairs share banks, the second pair also crosses lines
		begin_test(5);
		random_line(l);
		fork
			read_bytes(19'h10048, 6'd16);
			write_bytes(19'h10844, 6'd24, l);
		join
		random_line(l);
		fork
			read_bytes(19'h20478, 6'd20);
			write_bytes(19'h20c3c, 6'd12, l);
		join
		read_bytes(19'h10844, 6'd24);
		read_bytes(19'h20c3c, 6'd12);
		end_test();

		// rows 0 to 15 of every region, so reads often land on earlier writes
		begin_test(6);
		for (int i = 0; i < RANDOM_OPS; i++) begin
			draw(stim_lfsr, 1, op);
			draw(stim_lfsr, 3, rgn);
			draw(stim_lfsr, 10, low);
			draw(stim_lfsr, 5, sz);
			a = {rgn[2:0], 6'd0, low[9:0]};
			s = size_t'(sz[4:0]) + 6'd1;
			if (op[0]) begin
				random_line(l);
				write_bytes(a, s, l);
			end else begin
				read_bytes(a, s);
			end
		end
		end_test();

		@(posedge clk);
		run_end <= 1'b1;
		@(posedge clk);
		run_end <= 1'b0;
		@(posedge clk);
		if (err_total == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* sources.f */
+incdir+logic
logic/mem_ctrl_pkg.sv
logic/line_req_if.sv
logic/read_path.sv
logic/write_path.sv
logic/bank_port_mux.sv
logic/mem_req_ctrl.sv
tb/mem_req_ctrl_checker.sv
tb/mem_req_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and judges the log

BUILD_DIR=obj_dir
SIM=mem_req_ctrl_sim
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module mem_req_ctrl_tb \
	-Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
